// File: logic/brch_macros.svh
`ifndef BRCH_MACROS_SVH
`define BRCH_MACROS_SVH

// instruction group shape
`define BRCH_INST_W 66 // full decoded word per slot
`define BRCH_ISSUE  4  // slots per rename group

// tag and rob position widths
`define BRCH_TAG_W  6
`define BRCH_POS_W  7  // also width of nxt_indx

// tracking queue, depth must be a power of two
`define BRCH_DEPTH  2
`define BRCH_PTR_W  $clog2(`BRCH_DEPTH)
`define BRCH_CNT_W  $clog2(`BRCH_DEPTH + 1) // must hold DEPTH itself

`endif

// File: logic/brch_pkg.sv
`include "brch_macros.svh"

package brch_pkg;

   // tag handed out per branch, low bits of nxt_indx plus slot
   typedef logic [`BRCH_TAG_W-1:0] brch_tag_t;

   // reorder buffer position, wraps at 7 bits
   typedef logic [`BRCH_POS_W-1:0] rob_pos_t;

   // index into the tracking queue
   typedef logic [`BRCH_PTR_W-1:0] brch_ptr_t;

   // live entry count / free room, 0..DEPTH
   typedef logic [`BRCH_CNT_W-1:0] brch_cnt_t;

endpackage

// File: logic/brch_tag_alloc.sv
`include "brch_macros.svh"
`timescale 1ns/1ns

module brch_tag_alloc
   import brch_pkg::*;
(
   input  logic [`BRCH_INST_W-1:0] inst0,
   input  logic [`BRCH_INST_W-1:0] inst1,
   input  logic [`BRCH_INST_W-1:0] inst2,
   input  logic [`BRCH_INST_W-1:0] inst3,
   input  logic [`BRCH_POS_W-1:0]  nxt_indx,     // low bits = tag of slot 0
   input  rob_pos_t                curr_pos,     // rob position of slot 0
   input  logic [2:0]              pr_need_inst, // slot k takes a rob entry
   output brch_tag_t               new_tag0,     // oldest branch
   output brch_tag_t               new_tag1,     // second oldest
   output rob_pos_t                new_pos0,
   output rob_pos_t                new_pos1,
   output logic [1:0]              new_cnt       // 0..2, extras dropped
);

   logic [`BRCH_INST_W-1:0] inst_arr [`BRCH_ISSUE];
   logic [`BRCH_ISSUE-1:0]  is_brch;
   logic [`BRCH_ISSUE-1:0]  need_ext; // last slot never adds to a younger one
   brch_tag_t               slot_tag [`BRCH_ISSUE];
   rob_pos_t                slot_pos [`BRCH_ISSUE];

   assign inst_arr[0] = inst0;
   assign inst_arr[1] = inst1;
   assign inst_arr[2] = inst2;
   assign inst_arr[3] = inst3;

   assign need_ext = {1'b0, pr_need_inst};

   // op class nonzero -> branch
   always_comb
   begin
      for (int k = 0; k < `BRCH_ISSUE; k++)
         is_brch[k] = |inst_arr[k][31:30];
   end

   // per slot tag and prefix summed position
   always_comb
   begin
      rob_pos_t run;
      run = curr_pos;
      for (int k = 0; k < `BRCH_ISSUE; k++)
      begin
         slot_tag[k] = nxt_indx[`BRCH_TAG_W-1:0] + brch_tag_t'(k); // wraps at 6 bits
         slot_pos[k] = run;
         run         = run + rob_pos_t'(need_ext[k]);
      end
   end

   // pick oldest two branches, slot 0 is oldest
   always_comb
   begin
      new_tag0 = '0;
      new_tag1 = '0;
      new_pos0 = '0;
      new_pos1 = '0;
      new_cnt  = 2'd0;
      for (int k = 0; k < `BRCH_ISSUE; k++)
      begin
         if (is_brch[k])
         begin
            if (new_cnt == 2'd0)
            begin
               new_tag0 = slot_tag[k];
               new_pos0 = slot_pos[k];
               new_cnt  = 2'd1;
            end
            else if (new_cnt == 2'd1)
            begin
               new_tag1 = slot_tag[k];
               new_pos1 = slot_pos[k];
               new_cnt  = 2'd2; // third / fourth ignored
            end
         end
      end
   end

endmodule

// File: logic/brch_occ_cnt.sv
`include "brch_macros.svh"
`timescale 1ns/1ns

module brch_occ_cnt
   import brch_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       stall,      // hold everything
   input  logic [1:0] alloc_n,    // entries written this cycle, already clipped
   input  logic       retire,     // head leaves
   input  brch_cnt_t  cut_to,     // survivors after mispredict
   input  logic       cut,
   output brch_cnt_t  count,
   output brch_cnt_t  free_slots  // registered, depth - count
);

   brch_cnt_t cnt_nxt;

   // mispredict overrides, alloc and retire can coexist
   always_comb
   begin
      if (cut)
         cnt_nxt = cut_to;
      else
         cnt_nxt = count + brch_cnt_t'(alloc_n) - brch_cnt_t'(retire);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         count      <= '0;
         free_slots <= brch_cnt_t'(`BRCH_DEPTH); // empty queue
      end
      else if (!stall)
      begin
         count      <= cnt_nxt;
         free_slots <= brch_cnt_t'(`BRCH_DEPTH) - cnt_nxt; // tracks count
      end
   end

endmodule

// File: logic/brch_track_ctrl.sv
`include "brch_macros.svh"
`timescale 1ns/1ns

module brch_track_ctrl
   import brch_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       stall,
   input  logic       mis_pred,
   input  brch_tag_t  brch_mis_indx,
   input  logic       cmt_brch,
   input  brch_tag_t  cmt_brch_indx,
   input  brch_cnt_t  count,                  // live entries
   input  brch_cnt_t  free_slots,             // room as of last edge
   input  logic [1:0] new_cnt,                // branches found in group
   input  brch_tag_t  ent_tag [`BRCH_DEPTH],  // index 0 = head
   input  rob_pos_t   ent_pos [`BRCH_DEPTH],
   output brch_ptr_t  head,
   output brch_ptr_t  tail,
   output logic       wr_en0,
   output logic       wr_en1,
   output logic [1:0] alloc_n,
   output logic       retire,
   output logic       cut,
   output brch_cnt_t  cut_to,
   output logic       flush,
   output rob_pos_t   flush_pos,
   output logic       all_nop
);

   logic      mis_hit;  // tag found among live entries
   brch_ptr_t hit_idx;  // head relative

   // mispredict lookup, oldest match wins
   always_comb
   begin
      mis_hit = 1'b0;
      hit_idx = '0;
      for (int i = 0; i < `BRCH_DEPTH; i++)
      begin
         if (!mis_hit && (brch_cnt_t'(i) < count) && (ent_tag[i] == brch_mis_indx))
         begin
            mis_hit = 1'b1;
            hit_idx = brch_ptr_t'(i);
         end
      end
   end

   assign flush     = mis_pred; // raised even on a miss
   assign all_nop   = mis_pred; // squash the group
   assign flush_pos = (mis_pred && mis_hit) ? ent_pos[hit_idx] : '0;

   // matched entry and younger are dropped, older ones survive
   assign cut    = mis_pred & mis_hit;
   assign cut_to = brch_cnt_t'(hit_idx);

   // commit only on head tag, mispredict wins
   assign retire = cmt_brch && !mis_pred && (count != '0) &&
                   (ent_tag[0] == cmt_brch_indx);

   // allocation clipped to free room, nothing under mispredict
   always_comb
   begin
      if (mis_pred)
         alloc_n = 2'd0;
      else if (brch_cnt_t'(new_cnt) > free_slots)
         alloc_n = 2'(free_slots); // < 2 here
      else
         alloc_n = new_cnt;
   end

   assign wr_en0 = (alloc_n != 2'd0); // oldest at tail
   assign wr_en1 = (alloc_n == 2'd2); // next at tail + 1

   // head pointer
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         head <= '0;
      else if (!stall && retire)
         head <= head + brch_ptr_t'(1);
   end

   // tail pointer, cut moves it back to the matched slot
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         tail <= '0;
      else if (!stall)
      begin
         if (cut)
            tail <= head + hit_idx;
         else
            tail <= tail + brch_ptr_t'(alloc_n); // wraps mod depth
      end
   end

endmodule

// File: logic/brch_pos_fifo.sv
`include "brch_macros.svh"
`timescale 1ns/1ns

module brch_pos_fifo
   import brch_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      stall,
   input  brch_ptr_t head,
   input  brch_ptr_t tail,
   input  logic      wr_en0,   // write at tail
   input  logic      wr_en1,   // write at tail + 1
   input  brch_tag_t wr_tag0,
   input  brch_tag_t wr_tag1,
   input  rob_pos_t  wr_pos0,
   input  rob_pos_t  wr_pos1,
   output brch_tag_t ent_tag [`BRCH_DEPTH], // rotated, 0 = head
   output rob_pos_t  ent_pos [`BRCH_DEPTH]
);

   brch_tag_t tag_mem [`BRCH_DEPTH];
   rob_pos_t  pos_mem [`BRCH_DEPTH];
   brch_ptr_t tail1;

   assign tail1 = tail + brch_ptr_t'(1);

   // entry storage, two write ports
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `BRCH_DEPTH; i++)
         begin
            tag_mem[i] <= '0;
            pos_mem[i] <= '0;
         end
      end
      else if (!stall)
      begin
         if (wr_en0)
         begin
            tag_mem[tail] <= wr_tag0;
            pos_mem[tail] <= wr_pos0;
         end
         if (wr_en1)
         begin
            tag_mem[tail1] <= wr_tag1;
            pos_mem[tail1] <= wr_pos1;
         end
      end
   end

   // head relative read view
   for (genvar i = 0; i < `BRCH_DEPTH; i++)
   begin : g_rd
      brch_ptr_t rd_idx;

      assign rd_idx     = head + brch_ptr_t'(i); // wraps
      assign ent_tag[i] = tag_mem[rd_idx];
      assign ent_pos[i] = pos_mem[rd_idx];
   end

endmodule

// File: logic/brch_unit.sv
`include "brch_macros.svh"
`timescale 1ns/1ns

module brch_unit
   import brch_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`BRCH_INST_W-1:0] inst0,
   input  logic [`BRCH_INST_W-1:0] inst1,
   input  logic [`BRCH_INST_W-1:0] inst2,
   input  logic [`BRCH_INST_W-1:0] inst3,
   input  logic [`BRCH_POS_W-1:0]  nxt_indx,
   input  rob_pos_t                curr_pos,
   input  logic [3:0]              pr_need_inst, // bit 3 not needed
   input  logic                    mis_pred,
   input  brch_tag_t               brch_mis_indx,
   input  logic                    cmt_brch,
   input  brch_tag_t               cmt_brch_indx,
   input  logic                    stall,
   output logic                    flush,
   output rob_pos_t                flush_pos,
   output logic                    all_nop,
   output brch_cnt_t               free_slots  // upstream holds back on 0
);

   brch_tag_t  new_tag0, new_tag1;
   rob_pos_t   new_pos0, new_pos1;
   logic [1:0] new_cnt;
   logic [1:0] alloc_n;
   logic       retire, cut;
   brch_cnt_t  cut_to, count;
   brch_ptr_t  head, tail;
   logic       wr_en0, wr_en1;
   brch_tag_t  ent_tag [`BRCH_DEPTH];
   rob_pos_t   ent_pos [`BRCH_DEPTH];

   brch_tag_alloc u_alloc (
      .inst0, .inst1, .inst2, .inst3,
      .nxt_indx, .curr_pos,
      .pr_need_inst (pr_need_inst[2:0]),
      .new_tag0, .new_tag1, .new_pos0, .new_pos1, .new_cnt
   );

   brch_occ_cnt u_occ (
      .clk, .rst_n, .stall,
      .alloc_n, .retire, .cut_to, .cut,
      .count, .free_slots
   );

   brch_track_ctrl u_ctrl (
      .clk, .rst_n, .stall,
      .mis_pred, .brch_mis_indx, .cmt_brch, .cmt_brch_indx,
      .count, .free_slots, .new_cnt,
      .ent_tag, .ent_pos,
      .head, .tail, .wr_en0, .wr_en1,
      .alloc_n, .retire, .cut, .cut_to,
      .flush, .flush_pos, .all_nop
   );

   brch_pos_fifo u_fifo (
      .clk, .rst_n, .stall,
      .head, .tail, .wr_en0, .wr_en1,
      .wr_tag0 (new_tag0),
      .wr_tag1 (new_tag1),
      .wr_pos0 (new_pos0),
      .wr_pos1 (new_pos1),
      .ent_tag, .ent_pos
   );

endmodule

// File: dv/brch_unit_tests.svh
`ifndef BRCH_UNIT_TESTS_SVH
`define BRCH_UNIT_TESTS_SVH

task automatic compare(string what, int exp, int act);
   assert (exp == act)
   else
   begin
      $display("mismatch %s %s: expected %0d actual %0d", cur_test, what, exp, act);
      errors++;
   end
endtask

function automatic logic [`BRCH_INST_W-1:0] make_inst(logic is_br);
   logic [95:0]             r;
   logic [`BRCH_INST_W-1:0] w;
   r = {$urandom(), $urandom(), $urandom()}; // random filler
   w = r[`BRCH_INST_W-1:0];
   w[31:30] = is_br ? 2'(1 + $urandom() % 3) : 2'b00; // op class
   return w;
endfunction

task automatic load_group(logic [3:0] mask, logic [6:0] nxt, rob_pos_t pos, logic [3:0] need);
   for (int k = 0; k < `BRCH_ISSUE; k++)
      inst_w[k] = make_inst(mask[k]);
   nxt_indx     = nxt;
   curr_pos     = pos;
   pr_need_inst = need;
endtask

task automatic clear_inputs();
   load_group(4'b0000, '0, '0, 4'b0000);
   mis_pred = 1'b0;
   brch_mis_indx = '0;
   cmt_brch = 1'b0;
   cmt_brch_indx = '0;
   stall = 1'b0;
endtask

// compare outputs with the queue model and step one clock
task automatic advance();
   int        hit;
   int        nb;
   int        room;
   logic      do_ret;
   brch_tag_t bt [2];
   rob_pos_t  bp [2];
   rob_pos_t  run;
   #1;
   hit = -1;
   for (int i = 0; i < m_tag.size(); i++)
   begin
      if (hit < 0 && m_tag[i] == brch_mis_indx)
         hit = i; // oldest live match
   end
   compare("flush", int'(mis_pred), int'(flush));
   compare("all_nop", int'(mis_pred), int'(all_nop));
   compare("flush_pos", (mis_pred && hit >= 0) ? int'(m_pos[hit]) : 0, int'(flush_pos));
   compare("free_slots", `BRCH_DEPTH - m_tag.size(), int'(free_slots));
   nb = 0;
   run = curr_pos;
   for (int k = 0; k < `BRCH_ISSUE; k++)
   begin
      if (inst_w[k][31:30] != 2'b00 && nb < 2)
      begin
         bt[nb] = nxt_indx[`BRCH_TAG_W-1:0] + brch_tag_t'(k);
         bp[nb] = run;
         nb++;
      end
      if (k < 3 && pr_need_inst[k])
         run = run + rob_pos_t'(1); // rob entry taken by slot k
   end
   room = `BRCH_DEPTH - m_tag.size(); // room as of last edge
   do_ret = cmt_brch && m_tag.size() > 0 && m_tag[0] == cmt_brch_indx;
   @(posedge clk);
   if (!stall && mis_pred && hit >= 0)
   begin
      while (m_tag.size() > hit)
      begin
         void'(m_tag.pop_back());
         void'(m_pos.pop_back());
      end
   end
   else if (!stall && !mis_pred)
   begin
      for (int j = 0; j < nb && j < room; j++)
      begin
         m_tag.push_back(bt[j]);
         m_pos.push_back(bp[j]);
      end
      if (do_ret)
      begin
         void'(m_tag.pop_front());
         void'(m_pos.pop_front());
      end
   end
   @(negedge clk);
endtask

task automatic close_test(int e0);
   if (errors == e0)
   begin
      tests_passed++;
      $display("%s: passed", cur_test);
   end
   else
   begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, errors - e0);
   end
endtask

task automatic reset_state();
   int e0;
   e0 = errors;
   cur_test = "reset_state";
   load_group(4'b0000, 7'h10, 7'd5, 4'b1111); // no branches
   #1;
   compare("free_slots", `BRCH_DEPTH, int'(free_slots));
   compare("flush", 0, int'(flush));
   advance();
   compare("free_slots after empty group", `BRCH_DEPTH, int'(free_slots));
   close_test(e0);
endtask

task automatic single_alloc_commit();
   int e0;
   e0 = errors;
   cur_test = "single_alloc_commit";
   load_group(4'b0100, 7'h15, 7'd100, 4'b0101); // tag 0x17 at pos 101
   advance();
   compare("free_slots", `BRCH_DEPTH - 1, int'(free_slots));
   clear_inputs();
   stall = 1'b1; // probe without cutting
   mis_pred = 1'b1;
   brch_mis_indx = 6'h17;
   #1;
   compare("flush_pos", 101, int'(flush_pos));
   advance();
   clear_inputs();
   cmt_brch = 1'b1;
   cmt_brch_indx = 6'h18; // wrong tag
   advance();
   compare("free_slots after bad commit", `BRCH_DEPTH - 1, int'(free_slots));
   cmt_brch_indx = 6'h17;
   advance();
   compare("free_slots after commit", `BRCH_DEPTH, int'(free_slots));
   close_test(e0);
endtask

task automatic two_branch_group();
   int e0;
   e0 = errors;
   cur_test = "two_branch_group";
   clear_inputs();
   load_group(4'b1010, 7'h20, 7'd10, 4'b1111); // tags 0x21 and 0x23 at pos 11 and 13
   advance();
   compare("free_slots full", 0, int'(free_slots));
   load_group(4'b0001, 7'h30, 7'd40, 4'b0000); // dropped for lack of room
   advance();
   compare("free_slots after drop", 0, int'(free_slots));
   clear_inputs();
   mis_pred = 1'b1;
   brch_mis_indx = 6'h30;
   #1;
   compare("flush on miss", 1, int'(flush));
   compare("flush_pos on miss", 0, int'(flush_pos));
   advance();
   compare("free_slots after miss", 0, int'(free_slots));
   close_test(e0);
endtask

task automatic mispredict_head();
   int e0;
   e0 = errors;
   cur_test = "mispredict_head";
   clear_inputs();
   load_group(4'b0001, 7'h02, 7'd50, 4'b0000); // allocation offered
   mis_pred = 1'b1;
   brch_mis_indx = 6'h21;
   cmt_brch = 1'b1; // commit offered too
   cmt_brch_indx = 6'h21;
   #1;
   compare("flush", 1, int'(flush));
   compare("all_nop", 1, int'(all_nop));
   compare("flush_pos", 11, int'(flush_pos));
   advance();
   compare("free_slots empty", `BRCH_DEPTH, int'(free_slots));
   close_test(e0);
endtask

task automatic mispredict_younger();
   int e0;
   e0 = errors;
   cur_test = "mispredict_younger";
   clear_inputs();
   load_group(4'b0011, 7'h08, 7'd60, 4'b0001); // 0x08 at 60 and 0x09 at 61
   advance();
   clear_inputs();
   mis_pred = 1'b1;
   brch_mis_indx = 6'h09;
   #1;
   compare("flush_pos", 61, int'(flush_pos));
   advance();
   compare("free_slots after cut", `BRCH_DEPTH - 1, int'(free_slots));
   clear_inputs();
   cmt_brch = 1'b1;
   cmt_brch_indx = 6'h08; // surviving head
   advance();
   compare("free_slots after commit", `BRCH_DEPTH, int'(free_slots));
   close_test(e0);
endtask

task automatic stall_and_random();
   int e0;
   e0 = errors;
   cur_test = "stall_and_random";
   clear_inputs();
   load_group(4'b0010, 7'h3e, 7'd126, 4'b1111); // tag 0x3f at pos 127
   advance();
   load_group(4'b1111, 7'h00, 7'd0, 4'b0000);
   stall = 1'b1;
   cmt_brch = 1'b1;
   cmt_brch_indx = 6'h3f;
   mis_pred = 1'b1;
   brch_mis_indx = 6'h3f;
   #1;
   compare("flush under stall", 1, int'(flush));
   compare("flush_pos under stall", 127, int'(flush_pos));
   advance();
   mis_pred = 1'b0;
   advance();
   compare("free_slots held", `BRCH_DEPTH - 1, int'(free_slots));
   for (int c = 0; c < 200; c++)
   begin
      load_group(4'($urandom()), 7'($urandom()), 7'($urandom()), 4'($urandom()));
      stall = ($urandom() % 8) == 0;
      mis_pred = ($urandom() % 6) == 0;
      cmt_brch = 1'($urandom());
      brch_mis_indx = brch_tag_t'($urandom());
      cmt_brch_indx = brch_tag_t'($urandom());
      if (m_tag.size() > 0 && $urandom() % 4 != 0)
         cmt_brch_indx = m_tag[0]; // mostly a live head
      if (m_tag.size() > 0 && $urandom() % 4 != 0)
         brch_mis_indx = m_tag[$urandom() % m_tag.size()];
      advance();
   end
   close_test(e0);
endtask

`endif

// File: dv/brch_unit_tb.sv
`include "brch_macros.svh"
`timescale 1ns/1ns

module brch_unit_tb
   import brch_pkg::*;
();

   // reset then clock edges per test in run order
   localparam int RUN_CYCLES = 3 + 1 + 4 + 3 + 1 + 3 + 3 + 200;
   localparam int CYCLE_LIMIT = RUN_CYCLES + 64; // slack margin

   logic                    clk;
   logic                    rst_n;
   logic [`BRCH_INST_W-1:0] inst_w [`BRCH_ISSUE]; // slot 0 oldest
   logic [`BRCH_POS_W-1:0]  nxt_indx;
   rob_pos_t                curr_pos;
   logic [3:0]              pr_need_inst;
   logic                    mis_pred;
   brch_tag_t               brch_mis_indx;
   logic                    cmt_brch;
   brch_tag_t               cmt_brch_indx;
   logic                    stall;
   logic                    flush;
   rob_pos_t                flush_pos;
   logic                    all_nop;
   brch_cnt_t               free_slots;

   brch_tag_t m_tag [$]; // reference queue with the head at index 0
   rob_pos_t  m_pos [$];
   string     cur_test;
   int        errors;
   int        tests_passed;
   int        tests_failed;
   int        cycle_cnt;

   brch_unit i_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .inst0         (inst_w[0]),
      .inst1         (inst_w[1]),
      .inst2         (inst_w[2]),
      .inst3         (inst_w[3]),
      .nxt_indx      (nxt_indx),
      .curr_pos      (curr_pos),
      .pr_need_inst  (pr_need_inst),
      .mis_pred      (mis_pred),
      .brch_mis_indx (brch_mis_indx),
      .cmt_brch      (cmt_brch),
      .cmt_brch_indx (cmt_brch_indx),
      .stall         (stall),
      .flush         (flush),
      .flush_pos     (flush_pos),
      .all_nop       (all_nop),
      .free_slots    (free_slots)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk; // 8 ns period
   end

   `include "brch_unit_tests.svh"

   initial
   begin
      void'($urandom(32'he620_ee4b)); // seed once
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      clear_inputs();
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1; // released on falling edge
      reset_state();
      single_alloc_commit();
      two_branch_group();
      mispredict_head();
      mispredict_younger();
      stall_and_random();
      $display("tests passed %0d, tests failed %0d, check errors %0d",
               tests_passed, tests_failed, errors);
      if (errors != 0 || tests_failed != 0)
         $display("TEST FAIL");
      else
         $display("TEST PASS");
      $finish;
   end

   // hang guard
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: brch_unit.f
+incdir+logic
+incdir+dv
logic/brch_pkg.sv
logic/brch_tag_alloc.sv
logic/brch_occ_cnt.sv
logic/brch_track_ctrl.sv
logic/brch_pos_fifo.sv
logic/brch_unit.sv
dv/brch_unit_tb.sv

// File: Bender.yml
package:
  name: brch_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/brch_pkg.sv
      - logic/brch_tag_alloc.sv
      - logic/brch_occ_cnt.sv
      - logic/brch_track_ctrl.sv
      - logic/brch_pos_fifo.sv
      - logic/brch_unit.sv
  - target: simulation
    include_dirs:
      - logic
      - dv
    files:
      - dv/brch_unit_tb.sv
